// ==== build.f ====
+incdir+rtl
rtl/trap_pkg.sv
rtl/exception_ctrl.sv
rtl/flush_timer.sv
rtl/trap_sequencer.sv
rtl/trap_csr_file.sv
rtl/trap_unit_top.sv
sim/trap_unit_tb.sv

// ==== sim/trap_unit_tb.sv ====
`timescale 1ns/1ps
`include "trap_params.svh"

module trap_unit_tb;

    // Reset sweep, 16 flag combinations and five directed cases
    localparam int NUM_CASES       = 22;
    localparam int WATCHDOG_CYCLES = NUM_CASES * (`TRAP_FLUSH_CYCLES + 8) + 100;
    localparam int READY_LIMIT     = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   id_valid;
    trap_pkg::id_stage_t    id;
    logic                   mret;
    trap_pkg::csr_req_t     csr_req;
    logic [`TRAP_XLEN-1:0]  csr_rdata;
    logic                   stall;
    logic                   redirect_valid;
    logic [`TRAP_XLEN-1:0]  redirect_pc;
    logic                   trap_taken;

    int     errors = 0;
    integer seed;

    // Reference model state
    int                     m_busy;
    logic                   m_ret;
    logic                   m_taken;
    logic [`TRAP_XLEN-1:0]  m_mtvec;
    logic [`TRAP_XLEN-1:0]  m_mepc;
    logic [`TRAP_XLEN-1:0]  m_mcause;
    logic [`TRAP_XLEN-1:0]  m_mtval;
    trap_pkg::trap_record_t m_rec;
    logic                   m_exc_accept;
    logic                   m_ret_accept;
    logic                   exp_stall;
    logic                   exp_redirect;
    logic [`TRAP_XLEN-1:0]  exp_pc;
    logic [`TRAP_XLEN-1:0]  exp_rdata;

    trap_unit_top trap_unit_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_valid       (id_valid),
        .id             (id),
        .mret           (mret),
        .csr_req        (csr_req),
        .csr_rdata      (csr_rdata),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .trap_taken     (trap_taken)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Classifier rules: jump squashes, then misaligned > illegal > ECALL
    function automatic trap_pkg::trap_record_t expected_record(input trap_pkg::id_stage_t s);
        trap_pkg::trap_record_t r;
        r.cause = trap_pkg::EXC_NONE;
        r.epc   = `TRAP_NO_EXC_EPC;
        r.tval  = '0;
        if (!s.jump && (s.i_addr_misaligned || s.illegal_ir || s.is_ecall))
        begin
            r.epc = s.pc;
            if (s.i_addr_misaligned)
            begin
                r.cause = trap_pkg::EXC_I_MISALIGN;
                r.tval  = s.pc;
            end
            else if (s.illegal_ir)
            begin
                r.cause = trap_pkg::EXC_ILLEGAL;
                r.tval  = s.ir;
            end
            else
            begin
                r.cause = trap_pkg::EXC_ECALL;
            end
        end
        return r;
    endfunction

    assign m_rec        = expected_record(id);
    // Requests only count while the model is idle
    assign m_exc_accept = (m_busy == 0) && id_valid && (m_rec.cause != trap_pkg::EXC_NONE);
    assign m_ret_accept = (m_busy == 0) && mret && !m_exc_accept;
    assign exp_stall    = (m_busy != 0);
    // Redirect sits in the last stall cycle
    assign exp_redirect = (m_busy == 1);
    assign exp_pc       = m_ret ? m_mepc : m_mtvec;

    always_comb
    begin
        case (csr_req.addr)
            `TRAP_CSR_MTVEC:  exp_rdata = m_mtvec;
            `TRAP_CSR_MEPC:   exp_rdata = m_mepc;
            `TRAP_CSR_MCAUSE: exp_rdata = m_mcause;
            `TRAP_CSR_MTVAL:  exp_rdata = m_mtval;
            default:          exp_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_busy   <= 0;
            m_ret    <= 1'b0;
            m_taken  <= 1'b0;
            m_mtvec  <= `TRAP_MTVEC_RESET;
            m_mepc   <= '0;
            m_mcause <= '0;
            m_mtval  <= '0;
        end
        else
        begin
            m_taken <= m_exc_accept;
            if (m_exc_accept)
            begin
                // Drain cycles plus the redirect cycle
                m_busy <= `TRAP_FLUSH_CYCLES + 1;
                m_ret  <= 1'b0;
            end
            else if (m_ret_accept)
            begin
                m_busy <= 1;
                m_ret  <= 1'b1;
            end
            else if (m_busy != 0)
            begin
                m_busy <= m_busy - 1;
            end
            if (csr_req.we && csr_req.addr == `TRAP_CSR_MTVEC)
            begin
                m_mtvec <= csr_req.wdata & ~`TRAP_XLEN'(3);
            end
            if (m_exc_accept)
            begin
                m_mepc   <= m_rec.epc;
                m_mcause <= `TRAP_XLEN'(m_rec.cause);
                m_mtval  <= m_rec.tval;
            end
            else if (csr_req.we)
            begin
                if (csr_req.addr == `TRAP_CSR_MEPC)   m_mepc   <= csr_req.wdata;
                if (csr_req.addr == `TRAP_CSR_MCAUSE) m_mcause <= csr_req.wdata;
                if (csr_req.addr == `TRAP_CSR_MTVAL)  m_mtval  <= csr_req.wdata;
            end
        end
    end

    // Port checks against the model, sampled at every rising edge
    stall_check: assert property (@(posedge clk) disable iff (!rst_n) stall == exp_stall)
        else
        begin
            errors++;
            $display("CHECK FAILED stall expected %h actual %h", $sampled(exp_stall),
                     $sampled(stall));
        end

    redirect_check: assert property (@(posedge clk) disable iff (!rst_n)
                                     redirect_valid == exp_redirect)
        else
        begin
            errors++;
            $display("CHECK FAILED redirect_valid expected %h actual %h",
                     $sampled(exp_redirect), $sampled(redirect_valid));
        end

    // Target only matters with the pulse
    target_check: assert property (@(posedge clk) disable iff (!rst_n)
                                   !exp_redirect || redirect_pc == exp_pc)
        else
        begin
            errors++;
            $display("CHECK FAILED redirect_pc expected %h actual %h", $sampled(exp_pc),
                     $sampled(redirect_pc));
        end

    taken_check: assert property (@(posedge clk) disable iff (!rst_n) trap_taken == m_taken)
        else
        begin
            errors++;
            $display("CHECK FAILED trap_taken expected %h actual %h", $sampled(m_taken),
                     $sampled(trap_taken));
        end

    rdata_check: assert property (@(posedge clk) disable iff (!rst_n) csr_rdata == exp_rdata)
        else
        begin
            errors++;
            $display("CHECK FAILED csr_rdata expected %h actual %h", $sampled(exp_rdata),
                     $sampled(csr_rdata));
        end

    // Inputs change 1 ns after the edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    // Holds the ID bundle and strobes for one edge, then drops them
    task automatic present_request(input trap_pkg::id_stage_t s, input logic valid,
                                   input logic ret);
        id       = s;
        id_valid = valid;
        mret     = ret;
        next_cycle();
        id_valid = 1'b0;
        mret     = 1'b0;
        id.i_addr_misaligned = 1'b0;
        id.illegal_ir        = 1'b0;
        id.is_ecall          = 1'b0;
        id.jump              = 1'b0;
    endtask

    // Waits for the sequencer to go idle again
    task automatic wait_ready;
        int cycles;
        cycles = 0;
        while (stall)
        begin
            if (cycles == READY_LIMIT)
            begin
                errors++;
                $display("The DUT held stall for more than %0d cycles", READY_LIMIT);
                break;
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [`TRAP_XLEN-1:0] data);
        csr_req.we    = 1'b1;
        csr_req.addr  = addr;
        csr_req.wdata = data;
        next_cycle();
        csr_req.we = 1'b0;
    endtask

    // Each read is checked at the next edge
    task automatic read_csr(input logic [11:0] addr);
        csr_req.addr = addr;
        next_cycle();
    endtask

    task automatic read_all_csrs;
        read_csr(`TRAP_CSR_MTVEC);
        read_csr(`TRAP_CSR_MEPC);
        read_csr(`TRAP_CSR_MCAUSE);
        read_csr(`TRAP_CSR_MTVAL);
    endtask

    // Random PC and IR with the given flags
    task automatic make_id(output trap_pkg::id_stage_t s, input logic [3:0] flags);
        s.pc                = $random(seed);
        s.ir                = $random(seed);
        s.i_addr_misaligned = flags[3];
        s.illegal_ir        = flags[2];
        s.is_ecall          = flags[1];
        s.jump              = flags[0];
    endtask

    initial
    begin
        trap_pkg::id_stage_t s;
        seed     = 53;
        rst_n    = 1'b0;
        id_valid = 1'b0;
        id       = '0;
        mret     = 1'b0;
        csr_req  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values, plus an unmapped address
        read_all_csrs();
        read_csr(12'h300);

        // Every flag combination, CSRs read back after each
        for (int f = 0; f < 16; f++)
        begin
            make_id(s, 4'(f));
            present_request(s, 1'b1, 1'b0);
            wait_ready();
            read_all_csrs();
        end

        // Flags without id_valid must not trap
        make_id(s, 4'b0100);
        present_request(s, 1'b0, 1'b0);
        read_csr(`TRAP_CSR_MEPC);

        // New vector with mode bits set, then a trap to it
        write_csr(`TRAP_CSR_MTVEC, $random(seed) | 32'h3);
        read_csr(`TRAP_CSR_MTVEC);
        make_id(s, 4'b0010);
        present_request(s, 1'b1, 1'b0);
        wait_ready();

        // Plain return to the captured mepc
        s = '0;
        present_request(s, 1'b0, 1'b1);
        wait_ready();

        // Exception and MRET together, the trap wins
        make_id(s, 4'b0100);
        present_request(s, 1'b1, 1'b1);
        wait_ready();
        read_all_csrs();

        // Capture beats a software mcause write, then requests while busy
        make_id(s, 4'b1000);
        csr_req.we    = 1'b1;
        csr_req.addr  = `TRAP_CSR_MCAUSE;
        csr_req.wdata = $random(seed);
        present_request(s, 1'b1, 1'b0);
        csr_req.we = 1'b0;
        make_id(s, 4'b0010);
        present_request(s, 1'b1, 1'b1);
        make_id(s, 4'b0100);
        present_request(s, 1'b1, 1'b1);
        wait_ready();
        read_all_csrs();
        repeat (2) next_cycle();

        $display("Error count: %0d", errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== rtl/trap_unit_top.sv ====
`timescale 1ns/1ps
`include "trap_params.svh"

module trap_unit_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // ID stage
    input  logic                  id_valid,
    input  trap_pkg::id_stage_t   id,
    input  logic                  mret,

    // Software CSR port
    input  trap_pkg::csr_req_t    csr_req,
    output logic [`TRAP_XLEN-1:0] csr_rdata,

    // Pipeline control
    output logic                  stall,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc,
    output logic                  trap_taken
);

    // Classifier outputs
    logic                   exc_raised;
    trap_pkg::trap_record_t exc_record;

    // Sequencer to CSR file and timer
    logic                   capture;
    logic                   flush_load;
    logic                   flush_done;

    // CSR file to sequencer
    logic [`TRAP_XLEN-1:0]  mtvec;
    logic [`TRAP_XLEN-1:0]  mepc;

    exception_ctrl exception_ctrl_i (
        .id         (id),
        .exc_raised (exc_raised),
        .exc_record (exc_record)
    );

    trap_sequencer trap_sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_valid       (id_valid),
        .exc_raised     (exc_raised),
        .mret           (mret),
        .flush_done     (flush_done),
        .flush_load     (flush_load),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .capture        (capture),
        .trap_taken     (trap_taken),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    flush_timer flush_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_load (flush_load),
        .flush_done (flush_done)
    );

    trap_csr_file trap_csr_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .exc_record (exc_record),
        .csr_req    (csr_req),
        .csr_rdata  (csr_rdata),
        .mtvec      (mtvec),
        .mepc       (mepc)
    );

endmodule

// ==== rtl/trap_csr_file.sv ====
`timescale 1ns/1ps
`include "trap_params.svh"

module trap_csr_file (
    input  logic                   clk,
    input  logic                   rst_n,

    // Trap capture from the sequencer
    input  logic                   capture,
    input  trap_pkg::trap_record_t exc_record,

    // Software access
    input  trap_pkg::csr_req_t     csr_req,
    output logic [`TRAP_XLEN-1:0]  csr_rdata,

    // Redirect targets
    output logic [`TRAP_XLEN-1:0]  mtvec,
    output logic [`TRAP_XLEN-1:0]  mepc
);

    logic [`TRAP_XLEN-1:0] mcause;
    logic [`TRAP_XLEN-1:0] mtval;

    // Write address decode
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    assign wr_mtvec  = csr_req.we && (csr_req.addr == `TRAP_CSR_MTVEC);
    assign wr_mepc   = csr_req.we && (csr_req.addr == `TRAP_CSR_MEPC);
    assign wr_mcause = csr_req.we && (csr_req.addr == `TRAP_CSR_MCAUSE);
    assign wr_mtval  = csr_req.we && (csr_req.addr == `TRAP_CSR_MTVAL);

    // Vector base only, traps never touch it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtvec <= `TRAP_MTVEC_RESET;
        end
        else if (wr_mtvec)
        begin
            // Direct mode so the mode bits read as zero
            mtvec <= {csr_req.wdata[`TRAP_XLEN-1:2], 2'b00};
        end
    end

    // Trap state, hardware capture beats a software write
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end
        else if (capture)
        begin
            mepc   <= exc_record.epc;
            // Cause code sits in the low bits
            mcause <= {{(`TRAP_XLEN - `TRAP_CAUSE_W){1'b0}}, exc_record.cause};
            mtval  <= exc_record.tval;
        end
        else
        begin
            if (wr_mepc)
            begin
                mepc <= csr_req.wdata;
            end
            if (wr_mcause)
            begin
                mcause <= csr_req.wdata;
            end
            if (wr_mtval)
            begin
                mtval <= csr_req.wdata;
            end
        end
    end

    // Read port
    always_comb
    begin
        case (csr_req.addr)
            `TRAP_CSR_MTVEC:  csr_rdata = mtvec;
            `TRAP_CSR_MEPC:   csr_rdata = mepc;
            `TRAP_CSR_MCAUSE: csr_rdata = mcause;
            `TRAP_CSR_MTVAL:  csr_rdata = mtval;
            // Unmapped addresses read as zero
            default:          csr_rdata = '0;
        endcase
    end

endmodule

// ==== rtl/trap_sequencer.sv ====
`timescale 1ns/1ps
`include "trap_params.svh"

module trap_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,

    // Pipeline requests
    input  logic                  id_valid,
    input  logic                  exc_raised,
    input  logic                  mret,

    // Drain timer
    input  logic                  flush_done,
    output logic                  flush_load,

    // Redirect targets from the CSR file
    input  logic [`TRAP_XLEN-1:0] mtvec,
    input  logic [`TRAP_XLEN-1:0] mepc,

    // Record capture into the CSR file
    output logic                  capture,

    // Pipeline control
    output logic                  trap_taken,
    output logic                  stall,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        REDIRECT_TRAP,
        REDIRECT_RET
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_nxt;

    // Requests are only seen when idle
    logic exc_accept;
    logic ret_accept;

    assign exc_accept = (state == IDLE) && id_valid && exc_raised;
    // An exception in the same cycle takes priority over MRET
    assign ret_accept = (state == IDLE) && mret && !exc_accept;

    // Capture and timer load happen at the accepting edge
    assign capture    = exc_accept;
    assign flush_load = exc_accept;

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (exc_accept)
                begin
                    state_nxt = DRAIN;
                end
                else if (ret_accept)
                begin
                    state_nxt = REDIRECT_RET;
                end
            end
            DRAIN:
            begin
                // Wait for the pipeline to empty
                if (flush_done)
                begin
                    state_nxt = REDIRECT_TRAP;
                end
            end
            // Both redirects last one cycle
            REDIRECT_TRAP: state_nxt = IDLE;
            REDIRECT_RET:  state_nxt = IDLE;
            default:       state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            trap_taken <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            // Pulse in the cycle after acceptance
            trap_taken <= capture;
        end
    end

    // Pipeline is held whenever a trap or return is in flight
    assign stall          = (state != IDLE);
    assign redirect_valid = (state == REDIRECT_TRAP) || (state == REDIRECT_RET);
    // Return goes to mepc, everything else to the vector
    assign redirect_pc    = (state == REDIRECT_RET) ? mepc : mtvec;

endmodule

// ==== rtl/flush_timer.sv ====
`timescale 1ns/1ps
`include "trap_params.svh"

module flush_timer (
    input  logic clk,
    input  logic rst_n,

    // Start of a pipeline drain
    input  logic flush_load,

    // Drain finishes at the next edge
    output logic flush_done
);

    // Wide enough to hold the full drain length
    localparam int CNT_W = $clog2(`TRAP_FLUSH_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (flush_load)
        begin
            // Restart the drain
            count <= CNT_W'(`TRAP_FLUSH_CYCLES);
        end
        else if (count != '0)
        begin
            count <= count - 1'b1;
        end
    end

    // High while one drain cycle remains
    // The sequencer moves on at that edge so the redirect
    // lands TRAP_FLUSH_CYCLES edges after the load
    assign flush_done = (count == CNT_W'(1));

endmodule

// ==== rtl/exception_ctrl.sv ====
`timescale 1ns/1ps
`include "trap_params.svh"

module exception_ctrl (
    // ID-stage bundle
    input  trap_pkg::id_stage_t    id,

    // Classification result
    output logic                   exc_raised,
    output trap_pkg::trap_record_t exc_record
);

    // Selected cause after suppression and priority
    trap_pkg::exc_cause_t cause;

    always_comb
    begin
        cause = trap_pkg::EXC_NONE;
        // The instruction in ID is squashed by a taken jump
        // So nothing it flags may trap
        if (!id.jump)
        begin
            // Misalignment goes first
            // An illegal flag seen together with it comes from the misaligned fetch
            if (id.i_addr_misaligned)
            begin
                cause = trap_pkg::EXC_I_MISALIGN;
            end
            else if (id.illegal_ir)
            begin
                cause = trap_pkg::EXC_ILLEGAL;
            end
            else if (id.is_ecall)
            begin
                cause = trap_pkg::EXC_ECALL;
            end
        end
    end

    assign exc_raised = (cause != trap_pkg::EXC_NONE);

    always_comb
    begin
        exc_record.cause = cause;

        // EPC points at the faulting instruction
        if (cause == trap_pkg::EXC_NONE)
        begin
            exc_record.epc = `TRAP_NO_EXC_EPC;
        end
        else
        begin
            exc_record.epc = id.pc;
        end

        // Trap value depends on the cause
        case (cause)
            // Faulting instruction word
            trap_pkg::EXC_ILLEGAL:    exc_record.tval = id.ir;
            // Faulting fetch address
            trap_pkg::EXC_I_MISALIGN: exc_record.tval = id.pc;
            // ECALL and no exception report zero
            default:                  exc_record.tval = '0;
        endcase
    end

endmodule

// ==== rtl/trap_pkg.sv ====
`include "trap_params.svh"

package trap_pkg;

    // Cause code as produced by the exception classifier
    typedef enum logic [`TRAP_CAUSE_W-1:0] {
        EXC_NONE       = `TRAP_EXC_NONE,
        EXC_I_MISALIGN = `TRAP_EXC_I_MISALIGN,
        EXC_ILLEGAL    = `TRAP_EXC_ILLEGAL,
        EXC_ECALL      = `TRAP_EXC_ECALL
    } exc_cause_t;

    // Everything the ID stage hands to the trap unit
    typedef struct packed {
        // Program counter of the instruction in ID
        logic [`TRAP_XLEN-1:0] pc;
        // Raw instruction word
        logic [`TRAP_XLEN-1:0] ir;
        // Carried over from IF
        logic                  i_addr_misaligned;
        // From the decoder
        logic                  illegal_ir;
        logic                  is_ecall;
        // Taken jump resolved in EX
        logic                  jump;
    } id_stage_t;

    // Classification result captured into the trap CSRs
    typedef struct packed {
        exc_cause_t            cause;
        logic [`TRAP_XLEN-1:0] epc;
        logic [`TRAP_XLEN-1:0] tval;
    } trap_record_t;

    // Software CSR access
    typedef struct packed {
        // Write strobe, read is always active
        logic                  we;
        logic [11:0]           addr;
        logic [`TRAP_XLEN-1:0] wdata;
    } csr_req_t;

endpackage

// ==== rtl/trap_params.svh ====
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// Data and address width
`define TRAP_XLEN           32

// Exception cause encoding of the classifier
`define TRAP_CAUSE_W        2
`define TRAP_EXC_NONE       2'd0
`define TRAP_EXC_I_MISALIGN 2'd1
`define TRAP_EXC_ILLEGAL    2'd2
`define TRAP_EXC_ECALL      2'd3

// Pipeline drain cycles between trap acceptance and redirect
`define TRAP_FLUSH_CYCLES   3

// Reset and default values
`define TRAP_NO_EXC_EPC     32'h0001_0000
`define TRAP_MTVEC_RESET    32'h0000_0100

// Machine-mode trap CSR addresses
`define TRAP_CSR_MTVEC      12'h305
`define TRAP_CSR_MEPC       12'h341
`define TRAP_CSR_MCAUSE     12'h342
`define TRAP_CSR_MTVAL      12'h343

`endif
